// File: verilog/mipsIsaPkg.sv
// MIPS32 instruction set constants
// field widths, opcodes, function codes and fixed registers
package mipsIsaPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int numRegs = 32;
	localparam int opWidth = 6;
	localparam int fnWidth = 6;
	localparam int shamtWidth = 5;
	localparam int immWidth = 16;
	localparam int targetWidth = 26;	// J/JAL word index

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// --------------------
	// primary opcodes
	localparam logic [opWidth-1:0] opSpecial = 6'b000000;
	localparam logic [opWidth-1:0] opRegimm = 6'b000001;
	localparam logic [opWidth-1:0] opJ = 6'b000010;
	localparam logic [opWidth-1:0] opJal = 6'b000011;
	localparam logic [opWidth-1:0] opBeq = 6'b000100;
	localparam logic [opWidth-1:0] opBne = 6'b000101;
	localparam logic [opWidth-1:0] opBlez = 6'b000110;
	localparam logic [opWidth-1:0] opBgtz = 6'b000111;
	localparam logic [opWidth-1:0] opAddi = 6'b001000;
	localparam logic [opWidth-1:0] opAddiu = 6'b001001;
	localparam logic [opWidth-1:0] opSlti = 6'b001010;
	localparam logic [opWidth-1:0] opSltiu = 6'b001011;
	localparam logic [opWidth-1:0] opAndi = 6'b001100;
	localparam logic [opWidth-1:0] opOri = 6'b001101;
	localparam logic [opWidth-1:0] opXori = 6'b001110;
	localparam logic [opWidth-1:0] opLui = 6'b001111;
	localparam logic [opWidth-1:0] opLb = 6'b100000;
	localparam logic [opWidth-1:0] opLh = 6'b100001;
	localparam logic [opWidth-1:0] opLw = 6'b100011;
	localparam logic [opWidth-1:0] opLbu = 6'b100100;
	localparam logic [opWidth-1:0] opLhu = 6'b100101;
	localparam logic [opWidth-1:0] opSb = 6'b101000;
	localparam logic [opWidth-1:0] opSh = 6'b101001;
	localparam logic [opWidth-1:0] opSw = 6'b101011;

	// --------------------
	// SPECIAL function field
	localparam logic [fnWidth-1:0] fnSll = 6'b000000;
	localparam logic [fnWidth-1:0] fnSrl = 6'b000010;
	localparam logic [fnWidth-1:0] fnSra = 6'b000011;
	localparam logic [fnWidth-1:0] fnSllv = 6'b000100;
	localparam logic [fnWidth-1:0] fnSrlv = 6'b000110;
	localparam logic [fnWidth-1:0] fnSrav = 6'b000111;
	localparam logic [fnWidth-1:0] fnJr = 6'b001000;
	localparam logic [fnWidth-1:0] fnJalr = 6'b001001;
	localparam logic [fnWidth-1:0] fnSyscall = 6'b001100;
	localparam logic [fnWidth-1:0] fnAdd = 6'b100000;
	localparam logic [fnWidth-1:0] fnAddu = 6'b100001;
	localparam logic [fnWidth-1:0] fnSub = 6'b100010;
	localparam logic [fnWidth-1:0] fnSubu = 6'b100011;
	localparam logic [fnWidth-1:0] fnAnd = 6'b100100;
	localparam logic [fnWidth-1:0] fnOr = 6'b100101;
	localparam logic [fnWidth-1:0] fnXor = 6'b100110;
	localparam logic [fnWidth-1:0] fnNor = 6'b100111;
	localparam logic [fnWidth-1:0] fnSlt = 6'b101010;
	localparam logic [fnWidth-1:0] fnSltu = 6'b101011;

	// REGIMM selectors in the rt field
	localparam regAddr_t rtBltz = 5'b00000;
	localparam regAddr_t rtBgez = 5'b00001;

	localparam regAddr_t linkReg = 5'd31;	// return address
	localparam regAddr_t resultReg = 5'd2;	// function result, v0
	localparam word_t linkOffset = 32'd4;

endpackage

// File: verilog/decodeCtrlPkg.sv
// decode stage control types
// ALU operations, branch and jump kinds, and the decoded control word
package decodeCtrlPkg;

	import mipsIsaPkg::*;

	// ALU op travels in a field as wide as the function code
	typedef enum logic [fnWidth-1:0] {
		aluNop = 6'd0,
		aluAdd = 6'd1,
		aluAddu = 6'd2,
		aluSub = 6'd3,
		aluSubu = 6'd4,
		aluAnd = 6'd5,
		aluOr = 6'd6,
		aluXor = 6'd7,
		aluNor = 6'd8,
		aluSlt = 6'd9,
		aluSltu = 6'd10,
		aluSll = 6'd11,
		aluSrl = 6'd12,
		aluSra = 6'd13,
		aluSllv = 6'd14,
		aluSrlv = 6'd15,
		aluSrav = 6'd16,
		aluLui = 6'd17
	} aluOp_t;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLez,
		brGtz,
		brLtz,
		brGez
	} branchKind_t;

	typedef enum logic [1:0] {
		jmpNone,
		jmpImm,	// target field of J/JAL
		jmpReg	// JR/JALR, target in rs
	} jumpKind_t;

	typedef struct packed {
		logic link;	// writes pc+4 to the return register
		logic regDst;	// destination from rd
		logic aluSrc;	// operand B is the immediate
		logic signExt;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
		logic sysCall;
		logic illegal;
		branchKind_t branch;
		jumpKind_t jump;
		aluOp_t aluOp;
	} decodeCtrl_t;

	localparam decodeCtrl_t ctrlNone = '0;	// every control inactive

endpackage

// File: verilog/regReadIf.sv
// register file read bus
// two source reads plus the always visible result register
`timescale 1ns/1ns

interface regReadIf import mipsIsaPkg::*; ();

	regAddr_t rsAddr;
	regAddr_t rtAddr;
	word_t rsData;
	word_t rtData;
	word_t r2Value;	// register 2, no address needed

	modport stage (
		output rsAddr,
		output rtAddr,
		input rsData,
		input rtData,
		input r2Value
	);

	modport regs (
		input rsAddr,
		input rtAddr,
		output rsData,
		output rtData,
		output r2Value
	);

endinterface

// File: verilog/instrDecoder.sv
// instruction decoder
// opcode, function and REGIMM fields into one control word
`timescale 1ns/1ns

module instrDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
	input word_t instr,
	output decodeCtrl_t ctrl
);

	logic [opWidth-1:0] opcode;
	logic [fnWidth-1:0] fn;
	regAddr_t rtField;

	assign opcode = instr[dataWidth-1 -: opWidth];
	assign fn = instr[fnWidth-1:0];
	assign rtField = instr[20:16];

	// --------------------
	// control word builders
	function automatic decodeCtrl_t rType(aluOp_t op);
		decodeCtrl_t c;
		c = ctrlNone;
		c.regDst = 1'b1;
		c.regWrite = 1'b1;
		c.aluOp = op;
		return c;
	endfunction

	function automatic decodeCtrl_t immOp(aluOp_t op, logic sx);
		decodeCtrl_t c;
		c = ctrlNone;
		c.aluSrc = 1'b1;
		c.regWrite = 1'b1;
		c.signExt = sx;
		c.aluOp = op;
		return c;
	endfunction

	// address is always base plus signed offset
	function automatic decodeCtrl_t memOp(logic isLoad);
		decodeCtrl_t c;
		c = ctrlNone;
		c.aluSrc = 1'b1;
		c.signExt = 1'b1;
		c.aluOp = aluAdd;
		c.memRead = isLoad;
		c.memToReg = isLoad;
		c.regWrite = isLoad;
		c.memWrite = !isLoad;
		return c;
	endfunction

	function automatic decodeCtrl_t branchOp(branchKind_t kind);
		decodeCtrl_t c;
		c = ctrlNone;
		c.branch = kind;
		return c;
	endfunction

	// pc+4 goes down the pipe as an add
	function automatic decodeCtrl_t jumpOp(jumpKind_t kind, logic doLink);
		decodeCtrl_t c;
		c = ctrlNone;
		c.jump = kind;
		c.link = doLink;
		c.regWrite = doLink;
		c.aluOp = doLink ? aluAdd : aluNop;
		return c;
	endfunction

	// --------------------
	always_comb begin
		ctrl = ctrlNone;
		case (opcode)
			opSpecial: begin
				case (fn)
					fnSll: ctrl = rType(aluSll);
					fnSrl: ctrl = rType(aluSrl);
					fnSra: ctrl = rType(aluSra);
					fnSllv: ctrl = rType(aluSllv);
					fnSrlv: ctrl = rType(aluSrlv);
					fnSrav: ctrl = rType(aluSrav);
					fnAdd: ctrl = rType(aluAdd);
					fnAddu: ctrl = rType(aluAddu);
					fnSub: ctrl = rType(aluSub);
					fnSubu: ctrl = rType(aluSubu);
					fnAnd: ctrl = rType(aluAnd);
					fnOr: ctrl = rType(aluOr);
					fnXor: ctrl = rType(aluXor);
					fnNor: ctrl = rType(aluNor);
					fnSlt: ctrl = rType(aluSlt);
					fnSltu: ctrl = rType(aluSltu);
					fnJr: ctrl = jumpOp(jmpReg, 1'b0);
					fnJalr: ctrl = jumpOp(jmpReg, 1'b1);
					fnSyscall: begin
						ctrl.sysCall = 1'b1;
						ctrl.aluOp = aluAdd;	// r2 passes through to EX
					end
					default: ctrl.illegal = 1'b1;
				endcase
			end
			opRegimm: begin
				case (rtField)
					rtBltz: ctrl = branchOp(brLtz);
					rtBgez: ctrl = branchOp(brGez);
					default: ctrl.illegal = 1'b1;
				endcase
			end
			opJ: ctrl = jumpOp(jmpImm, 1'b0);
			opJal: ctrl = jumpOp(jmpImm, 1'b1);
			opBeq: ctrl = branchOp(brEq);
			opBne: ctrl = branchOp(brNe);
			opBlez: ctrl = branchOp(brLez);
			opBgtz: ctrl = branchOp(brGtz);
			opAddi: ctrl = immOp(aluAdd, 1'b1);
			opAddiu: ctrl = immOp(aluAddu, 1'b1);
			opSlti: ctrl = immOp(aluSlt, 1'b1);
			opSltiu: ctrl = immOp(aluSltu, 1'b1);
			opAndi: ctrl = immOp(aluAnd, 1'b0);	// logical ops zero-extend
			opOri: ctrl = immOp(aluOr, 1'b0);
			opXori: ctrl = immOp(aluXor, 1'b0);
			opLui: ctrl = immOp(aluLui, 1'b0);
			opLb, opLh, opLw, opLbu, opLhu: ctrl = memOp(1'b1);
			opSb, opSh, opSw: ctrl = memOp(1'b0);
			default: ctrl.illegal = 1'b1;
		endcase
	end

	// no entry of the table both reads and writes memory
	memAccessExcl: assert final (!(ctrl.memRead && ctrl.memWrite))
		else $error("decoder set memRead and memWrite together");

endmodule

// File: verilog/registerFile.sv
// general purpose register file, 32 x 32
// one write port, two addressed reads and a fixed read of register 2
`timescale 1ns/1ns

module registerFile import mipsIsaPkg::*; (
	input logic CLK,
	regReadIf.regs rd,
	input logic wbEnable,
	input regAddr_t wbAddr,
	input word_t wbData
);

	word_t regs [numRegs];

	// --------------------
	// write at the edge, so a same-cycle read sees the old word
	always_ff @(posedge CLK) begin
		if (wbEnable && (wbAddr != '0)) begin
			regs[wbAddr] <= wbData;
		end
	end

	// --------------------
	// combinational reads, $zero hardwired
	assign rd.rsData = (rd.rsAddr == '0) ? '0 : regs[rd.rsAddr];
	assign rd.rtData = (rd.rtAddr == '0) ? '0 : regs[rd.rtAddr];
	assign rd.r2Value = regs[resultReg];	// function result register

	// writeback must name a real register whenever it fires
	wbAddrKnown: assert property (@(posedge CLK) wbEnable |-> !$isunknown(wbAddr))
		else $error("writeback enabled with unknown address %h", wbAddr);

endmodule

// File: verilog/branchResolver.sv
// branch and jump resolution
// evaluates the branch condition and picks the next fetch address
`timescale 1ns/1ns

module branchResolver import mipsIsaPkg::*, decodeCtrlPkg::*; (
	input decodeCtrl_t ctrl,
	input word_t instr,
	input word_t pc,	// already incremented
	input word_t rsData,
	input word_t rtData,
	output logic takenBranch,
	output word_t nextPc
);

	logic signed [dataWidth-1:0] rsSigned;
	logic condMet;
	word_t branchOffset;
	word_t branchTarget;
	word_t jumpTarget;

	assign rsSigned = rsData;

	// --------------------
	// targets
	assign branchOffset = {{(dataWidth-immWidth-2){instr[immWidth-1]}},
		instr[immWidth-1:0], 2'b00};	// word offset, sign-extended
	assign branchTarget = pc + branchOffset;
	assign jumpTarget = {pc[dataWidth-1 -: 4], instr[targetWidth-1:0], 2'b00};	// same 256MB region

	// --------------------
	// condition, compares against zero are signed
	always_comb begin
		case (ctrl.branch)
			brEq: condMet = (rsData == rtData);
			brNe: condMet = (rsData != rtData);
			brLez: condMet = (rsSigned <= 0);
			brGtz: condMet = (rsSigned > 0);
			brLtz: condMet = (rsSigned < 0);
			brGez: condMet = (rsSigned >= 0);
			default: condMet = 1'b0;
		endcase
	end

	assign takenBranch = condMet || (ctrl.jump != jmpNone);

	always_comb begin
		case (ctrl.jump)
			jmpImm: nextPc = jumpTarget;
			jmpReg: nextPc = rsData;
			default: nextPc = condMet ? branchTarget : pc;	// fall through keeps pc+4
		endcase
	end

endmodule

// File: verilog/decodeStage.sv
// MIPS instruction decode stage
// decode, register read, branch resolution and the ID/EX register
`timescale 1ns/1ns

module decodeStage import mipsIsaPkg::*, decodeCtrlPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic FREEZE,
	input logic BUBBLE,
	input word_t instr,
	input word_t pc,
	input word_t r2Input,
	input logic wbEnable,
	input regAddr_t wbAddr,
	input word_t wbData,
	output word_t exOpA,
	output word_t exOpB,
	output word_t exRtData,
	output regAddr_t exWriteReg,
	output regAddr_t exRsAddr,
	output regAddr_t exRtAddr,
	output logic [shamtWidth-1:0] exShamt,
	output word_t exImm,
	output aluOp_t exAluOp,
	output logic exAluSrc,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exMemToReg,
	output logic exDoWriteback,
	output logic exTakenBranch,
	output logic sysCall,
	output logic illegalInstr,
	output word_t nextPc,
	output logic takenBranch,
	output word_t r2Value
);

	typedef struct packed {
		word_t opA;
		word_t opB;
		word_t rtData;
		regAddr_t writeReg;
		regAddr_t rsAddr;
		regAddr_t rtAddr;
		logic [shamtWidth-1:0] shamt;
		word_t imm;
		aluOp_t aluOp;
		logic aluSrc;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic doWriteback;
		logic takenBranch;
		logic sysCall;
		logic illegal;
	} idEx_t;

	decodeCtrl_t ctrl;
	idEx_t idExNext;
	idEx_t idEx;
	regAddr_t rsField;
	regAddr_t rtField;
	regAddr_t rdField;
	logic rsUnused;
	logic rtUnused;

	regReadIf rdBus();

	assign rsField = instr[25:21];
	assign rtField = instr[20:16];
	assign rdField = instr[15:11];

	assign rdBus.rsAddr = rsField;
	assign rdBus.rtAddr = rtField;
	assign r2Value = rdBus.r2Value;

	instrDecoder u0 (
		.instr(instr),
		.ctrl(ctrl)
	);

	registerFile u1 (
		.CLK(CLK),
		.rd(rdBus.regs),
		.wbEnable(wbEnable),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	branchResolver u2 (
		.ctrl(ctrl),
		.instr(instr),
		.pc(pc),
		.rsData(rdBus.rsData),
		.rtData(rdBus.rtData),
		.takenBranch(takenBranch),
		.nextPc(nextPc)
	);

	// --------------------
	// source addresses EX never reads go forward as $zero
	assign rsUnused = ctrl.link || ctrl.sysCall || ctrl.illegal || (ctrl.jump == jmpImm);
	assign rtUnused = ctrl.aluSrc || ctrl.link || ctrl.sysCall || ctrl.illegal
		|| (ctrl.jump != jmpNone) || (ctrl.branch inside {brLez, brGtz, brLtz, brGez});

	always_comb begin
		idExNext.opA = ctrl.link ? pc : (ctrl.sysCall ? r2Input : rdBus.rsData);
		idExNext.opB = ctrl.link ? linkOffset : (ctrl.sysCall ? '0 : rdBus.rtData);
		idExNext.rtData = rdBus.rtData;	// store data
		if (ctrl.regDst)
			idExNext.writeReg = rdField;
		else if (ctrl.link)
			idExNext.writeReg = linkReg;
		else if (ctrl.sysCall || ctrl.illegal)
			idExNext.writeReg = '0;
		else
			idExNext.writeReg = rtField;
		idExNext.rsAddr = rsUnused ? '0 : rsField;
		idExNext.rtAddr = rtUnused ? '0 : rtField;
		idExNext.shamt = instr[10:6];
		idExNext.imm = ctrl.signExt
			? {{(dataWidth-immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]}
			: {{(dataWidth-immWidth){1'b0}}, instr[immWidth-1:0]};
		idExNext.aluOp = ctrl.aluOp;
		idExNext.aluSrc = ctrl.aluSrc;
		idExNext.memRead = ctrl.memRead;
		idExNext.memWrite = ctrl.memWrite;
		idExNext.memToReg = ctrl.memToReg;
		idExNext.doWriteback = ctrl.regWrite || ctrl.memToReg;
		idExNext.takenBranch = takenBranch;
		idExNext.sysCall = ctrl.sysCall;
		idExNext.illegal = ctrl.illegal;
	end

	// --------------------
	// ID/EX register, bubble beats freeze
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			idEx <= '0;
		end else if (BUBBLE) begin
			idEx <= '0;
		end else if (!FREEZE) begin
			idEx <= idExNext;
		end
	end

	assign exOpA = idEx.opA;
	assign exOpB = idEx.opB;
	assign exRtData = idEx.rtData;
	assign exWriteReg = idEx.writeReg;
	assign exRsAddr = idEx.rsAddr;
	assign exRtAddr = idEx.rtAddr;
	assign exShamt = idEx.shamt;
	assign exImm = idEx.imm;
	assign exAluOp = idEx.aluOp;
	assign exAluSrc = idEx.aluSrc;
	assign exMemRead = idEx.memRead;
	assign exMemWrite = idEx.memWrite;
	assign exMemToReg = idEx.memToReg;
	assign exDoWriteback = idEx.doWriteback;
	assign exTakenBranch = idEx.takenBranch;
	assign sysCall = idEx.sysCall;
	assign illegalInstr = idEx.illegal;

	// an illegal word must reach EX as a harmless no-op
	illegalIsNop: assert property (@(posedge CLK) disable iff (!RESET)
		illegalInstr |-> (exAluOp == aluNop) && !(exAluSrc || exMemRead || exMemWrite
			|| exMemToReg || exDoWriteback || exTakenBranch || sysCall))
		else $error("illegal instruction left active controls in ID/EX");

endmodule

// File: bench/decodeStageTb.sv
// testbench for the MIPS decode stage
// directed tests with a mirrored register file and a cycle limit
`timescale 1ns/1ns

module decodeStageTb import mipsIsaPkg::*, decodeCtrlPkg::*; ();

	localparam int maxCycles = 400;	// well above the directed sequence

	logic CLK;
	logic RESET;
	logic FREEZE;
	logic BUBBLE;
	word_t instr;
	word_t pc;
	word_t r2Input;
	logic wbEnable;
	regAddr_t wbAddr;
	word_t wbData;
	word_t exOpA;
	word_t exOpB;
	word_t exRtData;
	regAddr_t exWriteReg;
	regAddr_t exRsAddr;
	regAddr_t exRtAddr;
	logic [shamtWidth-1:0] exShamt;
	word_t exImm;
	aluOp_t exAluOp;
	logic exAluSrc;
	logic exMemRead;
	logic exMemWrite;
	logic exMemToReg;
	logic exDoWriteback;
	logic exTakenBranch;
	logic sysCall;
	logic illegalInstr;
	word_t nextPc;
	logic takenBranch;
	word_t r2Value;

	word_t regMirror [numRegs];	// what the register file should hold
	int errors = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycles = 0;

	decodeStage dut0 (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("run stopped, no end of tests after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------
	// instruction encoders
	function automatic word_t rInstr(regAddr_t rs, regAddr_t rt, regAddr_t rd,
		logic [5:0] fn);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iInstr(logic [5:0] op, regAddr_t rs, regAddr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jInstr(logic [5:0] op, logic [25:0] target);
		return {op, target};
	endfunction

	// pc plus the word offset
	function automatic word_t branchDest(word_t pcVal, logic [15:0] imm);
		return pcVal + {{14{imm[15]}}, imm, 2'b00};
	endfunction

	// --------------------
	// timing and checking helpers
	task automatic advance();
		@(posedge CLK);
		#2;
	endtask

	task automatic latchOutputs();	// sample just before the following edge
		@(posedge CLK);
		#15;
	endtask

	task automatic apply(word_t i, word_t p);
		instr = i;
		pc = p;
	endtask

	task automatic checkVal(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic endTest(string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, testErrors);
			testsFailed++;
			errors += testErrors;
		end
		testErrors = 0;
	endtask

	task automatic writeReg(regAddr_t a, word_t d);
		wbEnable = 1'b1;
		wbAddr = a;
		wbData = d;
		advance();
		wbEnable = 1'b0;
		if (a != '0)
			regMirror[a] = d;
	endtask

	task automatic checkBranch(string name, word_t i, word_t p, logic taken);
		apply(i, p);
		#15;
		checkVal({name, " takenBranch"}, takenBranch, taken);
		checkVal({name, " nextPc"}, nextPc, taken ? branchDest(p, i[15:0]) : p);
		advance();
	endtask

	// --------------------
	// tests
	task automatic resetAndRegs();
		#15;	// still ahead of the first edge after reset
		checkVal("exAluOp", exAluOp, aluNop);
		checkVal("exAluSrc", exAluSrc, 0);
		checkVal("exMemRead", exMemRead, 0);
		checkVal("exMemWrite", exMemWrite, 0);
		checkVal("exMemToReg", exMemToReg, 0);
		checkVal("exDoWriteback", exDoWriteback, 0);
		checkVal("exTakenBranch", exTakenBranch, 0);
		checkVal("sysCall", sysCall, 0);
		checkVal("illegalInstr", illegalInstr, 0);
		advance();
		for (int r = 1; r < numRegs; r++)
			writeReg(r, $urandom());
		apply(rInstr(5'd3, 5'd7, 5'd5, fnAdd), 32'h0000_0400);
		latchOutputs();
		checkVal("exOpA", exOpA, regMirror[3]);
		checkVal("exOpB", exOpB, regMirror[7]);
		checkVal("exWriteReg", exWriteReg, 5);
		checkVal("exRsAddr", exRsAddr, 3);
		checkVal("exRtAddr", exRtAddr, 7);
		checkVal("exAluOp", exAluOp, aluAdd);
		checkVal("exDoWriteback", exDoWriteback, 1);
		advance();
		apply(rInstr(5'd0, 5'd9, 5'd4, fnAdd), 32'h0000_0404);	// rs is $zero
		latchOutputs();
		checkVal("exOpA", exOpA, 0);
		checkVal("exOpB", exOpB, regMirror[9]);
		checkVal("r2Value", r2Value, regMirror[resultReg]);
		advance();
		apply({opSpecial, 5'd0, 5'd7, 5'd4, 5'd13, fnSll}, 32'h0000_0408);	// shift by 13
		latchOutputs();
		checkVal("exShamt", exShamt, 13);
		checkVal("exAluOp", exAluOp, aluSll);
		checkVal("exOpB", exOpB, regMirror[7]);
		checkVal("exWriteReg", exWriteReg, 4);
		advance();
		endTest("reset and register file");
	endtask

	task automatic immAndMemory();
		apply(iInstr(opAddi, 5'd3, 5'd6, 16'hFFF0), 32'h0000_0500);
		latchOutputs();
		checkVal("exAluSrc", exAluSrc, 1);
		checkVal("exRsAddr", exRsAddr, 3);
		checkVal("exRtAddr", exRtAddr, 0);
		checkVal("exWriteReg", exWriteReg, 6);
		checkVal("exImm", exImm, 32'hFFFF_FFF0);
		checkVal("exOpA", exOpA, regMirror[3]);
		advance();
		apply(iInstr(opOri, 5'd3, 5'd6, 16'h8001), 32'h0000_0504);
		latchOutputs();
		checkVal("exImm", exImm, 32'h0000_8001);	// logical ops zero-extend
		advance();
		apply(iInstr(opLw, 5'd1, 5'd8, 16'h0004), 32'h0000_0508);
		latchOutputs();
		checkVal("exMemRead", exMemRead, 1);
		checkVal("exMemToReg", exMemToReg, 1);
		checkVal("exDoWriteback", exDoWriteback, 1);
		advance();
		apply(iInstr(opSw, 5'd1, 5'd9, 16'h0008), 32'h0000_050C);
		latchOutputs();
		checkVal("exMemWrite", exMemWrite, 1);
		checkVal("exDoWriteback", exDoWriteback, 0);
		checkVal("exRtData", exRtData, regMirror[9]);
		advance();
		endTest("immediates, loads and stores");
	endtask

	task automatic branches();
		writeReg(5'd10, 32'd5);
		writeReg(5'd11, 32'd5);
		writeReg(5'd12, 32'hFFFF_FFF8);	// negative
		writeReg(5'd14, 32'd7);
		checkBranch("beq", iInstr(opBeq, 5'd10, 5'd11, 16'hFFFC), 32'h0000_1000, 1);
		checkBranch("beq", iInstr(opBeq, 5'd10, 5'd14, 16'hFFFC), 32'h0000_1000, 0);
		checkBranch("bne", iInstr(opBne, 5'd10, 5'd14, 16'h0010), 32'h0000_2000, 1);
		checkBranch("bne", iInstr(opBne, 5'd10, 5'd11, 16'h0010), 32'h0000_2000, 0);
		checkBranch("blez", iInstr(opBlez, 5'd12, 5'd0, 16'h0020), 32'h0000_3000, 1);
		checkBranch("blez", iInstr(opBlez, 5'd10, 5'd0, 16'h0020), 32'h0000_3000, 0);
		checkBranch("bgtz", iInstr(opBgtz, 5'd10, 5'd0, 16'hFF00), 32'h0000_4000, 1);
		checkBranch("bgtz", iInstr(opBgtz, 5'd0, 5'd0, 16'hFF00), 32'h0000_4000, 0);
		checkBranch("bltz", iInstr(opRegimm, 5'd12, rtBltz, 16'h0040), 32'h0000_5000, 1);
		checkBranch("bltz", iInstr(opRegimm, 5'd0, rtBltz, 16'h0040), 32'h0000_5000, 0);
		checkBranch("bgez", iInstr(opRegimm, 5'd0, rtBgez, 16'h8000), 32'h0001_0000, 1);
		checkBranch("bgez", iInstr(opRegimm, 5'd12, rtBgez, 16'h8000), 32'h0001_0000, 0);
		endTest("branches");
	endtask

	task automatic jumpsAndLink();
		apply(jInstr(opJ, 26'h012_3456), 32'hA000_1000);
		#15;
		checkVal("takenBranch", takenBranch, 1);
		checkVal("nextPc", nextPc, {4'hA, 26'h012_3456, 2'b00});
		advance();
		apply(rInstr(5'd10, 5'd0, 5'd0, fnJr), 32'h0000_6000);
		#15;
		checkVal("nextPc", nextPc, regMirror[10]);
		advance();
		apply(jInstr(opJal, 26'h000_0100), 32'h0000_7004);
		latchOutputs();
		checkVal("exOpA", exOpA, 32'h0000_7004);
		checkVal("exOpB", exOpB, 4);
		checkVal("exWriteReg", exWriteReg, 31);
		checkVal("exTakenBranch", exTakenBranch, 1);
		advance();
		apply(rInstr(5'd14, 5'd0, 5'd17, fnJalr), 32'h0000_8000);	// rd is not the link
		#15;
		checkVal("nextPc", nextPc, regMirror[14]);
		latchOutputs();
		checkVal("exWriteReg", exWriteReg, 31);
		advance();
		endTest("jumps and link");
	endtask

	task automatic stallAndFlush();
		word_t newVal;
		newVal = $urandom();
		apply(rInstr(5'd3, 5'd7, 5'd5, fnAdd), 32'h0000_9000);
		latchOutputs();
		advance();
		FREEZE = 1'b1;
		apply(iInstr(opOri, 5'd1, 5'd2, 16'h00FF), 32'h0000_9004);
		wbEnable = 1'b1;
		wbAddr = 5'd20;
		wbData = newVal;
		latchOutputs();
		regMirror[20] = newVal;
		checkVal("exOpA", exOpA, regMirror[3]);
		checkVal("exAluOp", exAluOp, aluAdd);
		checkVal("exWriteReg", exWriteReg, 5);
		advance();
		wbEnable = 1'b0;
		FREEZE = 1'b0;
		apply(rInstr(5'd20, 5'd0, 5'd5, fnAdd), 32'h0000_9008);	// write landed under freeze
		latchOutputs();
		checkVal("exOpA", exOpA, regMirror[20]);
		advance();
		FREEZE = 1'b1;
		BUBBLE = 1'b1;
		latchOutputs();
		checkVal("exOpA", exOpA, 0);
		checkVal("exAluOp", exAluOp, aluNop);
		checkVal("exDoWriteback", exDoWriteback, 0);
		checkVal("exWriteReg", exWriteReg, 0);
		advance();
		FREEZE = 1'b0;
		BUBBLE = 1'b0;
		endTest("stall and flush");
	endtask

	task automatic syscallAndIllegal();
		r2Input = $urandom();
		apply({opSpecial, 20'h4_5678, fnSyscall}, 32'h0000_A000);	// code spans rs, rt, rd
		latchOutputs();
		checkVal("sysCall", sysCall, 1);
		checkVal("exOpA", exOpA, r2Input);
		checkVal("exOpB", exOpB, 0);
		checkVal("exWriteReg", exWriteReg, 0);
		checkVal("exRsAddr", exRsAddr, 0);
		advance();
		apply({6'b111111, 5'd3, 5'd7, 16'h1234}, 32'h0000_A004);	// no such opcode
		latchOutputs();
		checkVal("illegalInstr", illegalInstr, 1);
		checkVal("exAluOp", exAluOp, aluNop);
		checkVal("exAluSrc", exAluSrc, 0);
		checkVal("exMemRead", exMemRead, 0);
		checkVal("exMemWrite", exMemWrite, 0);
		checkVal("exMemToReg", exMemToReg, 0);
		checkVal("exDoWriteback", exDoWriteback, 0);
		checkVal("exTakenBranch", exTakenBranch, 0);
		checkVal("sysCall", sysCall, 0);
		checkVal("exWriteReg", exWriteReg, 0);
		advance();
		endTest("syscall and illegal");
	endtask

	// --------------------
	initial begin
		void'($urandom(38595));
		RESET = 1'b0;
		FREEZE = 1'b0;
		BUBBLE = 1'b0;
		instr = '0;
		pc = '0;
		r2Input = '0;
		wbEnable = 1'b0;
		wbAddr = '0;
		wbData = '0;
		for (int r = 0; r < numRegs; r++)
			regMirror[r] = '0;
		repeat (3) @(posedge CLK);
		#2;
		RESET = 1'b1;
		resetAndRegs();
		immAndMemory();
		branches();
		jumpsAndLink();
		stallAndFlush();
		syscallAndIllegal();
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: project.f
verilog/mipsIsaPkg.sv
verilog/decodeCtrlPkg.sv
verilog/regReadIf.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/branchResolver.sv
verilog/decodeStage.sv
bench/decodeStageTb.sv
